// ==== verilog/core_cfg.svh ====
`ifndef CORE_CFG_SVH
`define CORE_CFG_SVH

// data and address width
`define CORE_XLEN       32
`define CORE_REG_ADDR_W 5

// x0 counted, but never written
`define CORE_REG_COUNT  32

// first fetch after reset
`define CORE_RESET_PC   32'h0000_1000

// sequential pc step
`define CORE_INST_BYTES 4

`endif

// ==== verilog/core_pkg.sv ====
`include "core_cfg.svh"

package core_pkg;

    typedef enum logic [1:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_IMM
    } alu_op_e;

    typedef enum logic [1:0] {
        BR_NONE,
        BR_BEQ,
        BR_BNE,
        BR_JAL
    } br_op_e;

    typedef enum logic {
        WB_ALU,
        WB_PC
    } wb_sel_e;

    typedef struct packed {
        alu_op_e                     alu_op;
        br_op_e                      br_op;
        wb_sel_e                     wb_sel;
        logic                        rf_wen;
        logic [`CORE_REG_ADDR_W-1:0] rs1;
        logic [`CORE_REG_ADDR_W-1:0] rs2;
        logic [`CORE_REG_ADDR_W-1:0] rd;
        logic                        use_rs1;
        logic                        use_rs2;
        logic                        op2_is_imm;
    } ctrl_t;

    typedef struct packed {
        logic [`CORE_XLEN-1:0] pc;
        logic [`CORE_XLEN-1:0] inst;
    } stage_info_t;

    // result offered to younger instructions
    typedef struct packed {
        logic                        valid;
        logic                        fwdable;
        logic [`CORE_REG_ADDR_W-1:0] addr;
        logic [`CORE_XLEN-1:0]       wdata;
    } fw_t;

    typedef struct packed {
        logic                  valid;
        logic [`CORE_XLEN-1:0] pc;
        logic [`CORE_XLEN-1:0] inst;
    } fetch_resp_t;

    typedef struct packed {
        logic                  valid;
        logic [`CORE_XLEN-1:0] addr;
    } redirect_t;

    typedef struct packed {
        logic                        valid;
        logic [`CORE_XLEN-1:0]       pc;
        logic                        rf_wen;
        logic [`CORE_REG_ADDR_W-1:0] rd;
        logic [`CORE_XLEN-1:0]       wdata;
    } retire_t;

    ////////////////////////////////////////////////////
    // stage register contents
    ////////////////////////////////////////////////////

    typedef struct packed {
        stage_info_t           info;
        ctrl_t                 ctrl;
        logic [`CORE_XLEN-1:0] imm;
        fw_t                   fw;
    } ds_payload_t;

    typedef struct packed {
        stage_info_t           info;
        ctrl_t                 ctrl;
        logic [`CORE_XLEN-1:0] imm;
        logic [`CORE_XLEN-1:0] op1;
        logic [`CORE_XLEN-1:0] op2;
        logic [`CORE_XLEN-1:0] rs2;
        fw_t                   fw;
    } exe_payload_t;

    // rd, write enable and result all live in fw
    typedef struct packed {
        stage_info_t info;
        fw_t         fw;
    } wb_payload_t;

endpackage

// ==== verilog/stage_reg.sv ====
`timescale 1ns/1ps

module stage_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst_i,
    input  logic     load_i,
    input  logic     hold_i,
    input  logic     flush_i,
    input  payload_t data_i,
    output logic     valid_o,
    output logic     is_new_o,
    output payload_t data_o
);

    always_ff @(posedge clk) begin
        if (rst_i || flush_i) begin
            valid_o  <= 1'b0;
            is_new_o <= 1'b0;
        end else if (hold_i) begin
            is_new_o <= 1'b0;
        end else begin
            valid_o  <= load_i;
            is_new_o <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!hold_i) begin
            data_o <= data_i;
        end
    end

endmodule

// ==== verilog/reg_file.sv ====
`timescale 1ns/1ps
`include "core_cfg.svh"

module reg_file (
    input  logic                        clk,
    input  logic                        wen_i,
    input  logic [`CORE_REG_ADDR_W-1:0] waddr_i,
    input  logic [`CORE_XLEN-1:0]       wdata_i,
    input  logic [`CORE_REG_ADDR_W-1:0] raddr1_i,
    input  logic [`CORE_REG_ADDR_W-1:0] raddr2_i,
    output logic [`CORE_XLEN-1:0]       rdata1_o,
    output logic [`CORE_XLEN-1:0]       rdata2_o
);

    // x0 has no storage
    logic [`CORE_XLEN-1:0] regs [1:`CORE_REG_COUNT-1];

    always_ff @(posedge clk) begin
        if (wen_i && waddr_i != '0) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    assign rdata1_o = (raddr1_i == '0) ? '0 : regs[raddr1_i];
    assign rdata2_o = (raddr2_i == '0) ? '0 : regs[raddr2_i];

endmodule

// ==== verilog/inst_decode.sv ====
`timescale 1ns/1ps
`include "core_cfg.svh"

module inst_decode (
    input  logic [`CORE_XLEN-1:0] inst_i,
    output core_pkg::ctrl_t       ctrl_o,
    output logic [`CORE_XLEN-1:0] imm_o
);

    localparam logic [6:0] OP_REG    = 7'b0110011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_JAL    = 7'b1101111;

    logic [6:0]            opcode;
    logic [2:0]            funct3;
    logic [6:0]            funct7;
    logic [`CORE_XLEN-1:0] imm_i_type;
    logic [`CORE_XLEN-1:0] imm_u_type;
    logic [`CORE_XLEN-1:0] imm_b_type;
    logic [`CORE_XLEN-1:0] imm_j_type;
    logic                  writes;

    assign opcode = inst_i[6:0];
    assign funct3 = inst_i[14:12];
    assign funct7 = inst_i[31:25];

    // sign-extended immediate formats
    assign imm_i_type = {{20{inst_i[31]}}, inst_i[31:20]};
    assign imm_u_type = {inst_i[31:12], 12'b0};
    assign imm_b_type = {{19{inst_i[31]}}, inst_i[31], inst_i[7], inst_i[30:25],
                         inst_i[11:8], 1'b0};
    assign imm_j_type = {{11{inst_i[31]}}, inst_i[31], inst_i[19:12], inst_i[20],
                         inst_i[30:21], 1'b0};

    always_comb begin
        ctrl_o        = '0;
        ctrl_o.alu_op = core_pkg::ALU_ADD;
        ctrl_o.br_op  = core_pkg::BR_NONE;
        ctrl_o.wb_sel = core_pkg::WB_ALU;
        ctrl_o.rs1    = inst_i[19:15];
        ctrl_o.rs2    = inst_i[24:20];
        ctrl_o.rd     = inst_i[11:7];
        imm_o         = imm_i_type;
        writes        = 1'b0;

        case (opcode)
            OP_REG: begin
                if (funct3 == 3'b000 && (funct7 == 7'b0000000 || funct7 == 7'b0100000)) begin
                    writes         = 1'b1;
                    ctrl_o.use_rs1 = 1'b1;
                    ctrl_o.use_rs2 = 1'b1;
                    if (funct7[5]) begin
                        ctrl_o.alu_op = core_pkg::ALU_SUB;
                    end
                end
            end
            OP_IMM: begin
                if (funct3 == 3'b000) begin
                    writes            = 1'b1;
                    ctrl_o.use_rs1    = 1'b1;
                    ctrl_o.op2_is_imm = 1'b1;
                end
            end
            OP_LUI: begin
                writes        = 1'b1;
                ctrl_o.alu_op = core_pkg::ALU_IMM;
                imm_o         = imm_u_type;
            end
            OP_BRANCH: begin
                imm_o = imm_b_type;
                if (funct3 == 3'b000 || funct3 == 3'b001) begin
                    ctrl_o.use_rs1 = 1'b1;
                    ctrl_o.use_rs2 = 1'b1;
                    ctrl_o.br_op   = funct3[0] ? core_pkg::BR_BNE : core_pkg::BR_BEQ;
                end
            end
            OP_JAL: begin
                writes        = 1'b1;
                ctrl_o.br_op  = core_pkg::BR_JAL;
                ctrl_o.wb_sel = core_pkg::WB_PC;
                imm_o         = imm_j_type;
            end
            default: begin
                // unknown word retires as a no-op
                writes = 1'b0;
            end
        endcase

        ctrl_o.rf_wen = writes && (ctrl_o.rd != '0);
    end

endmodule

// ==== verilog/operand_select.sv ====
`timescale 1ns/1ps
`include "core_cfg.svh"

module operand_select (
    input  core_pkg::ctrl_t       ctrl_i,
    input  logic [`CORE_XLEN-1:0] imm_i,
    input  logic [`CORE_XLEN-1:0] rs1_data_i,
    input  logic [`CORE_XLEN-1:0] rs2_data_i,
    input  core_pkg::fw_t         fw_exe_i,
    input  core_pkg::fw_t         fw_wb_i,
    output logic [`CORE_XLEN-1:0] op1_o,
    output logic [`CORE_XLEN-1:0] op2_o,
    output logic [`CORE_XLEN-1:0] rs2_o,
    output logic                  hazard_o
);

    // exe holds the younger result, so a link value there wins over wb
    function automatic logic [`CORE_XLEN-1:0] fwd_value(
        input logic [`CORE_REG_ADDR_W-1:0] addr,
        input logic [`CORE_XLEN-1:0]       rf_data
    );
        if (addr == '0) begin
            return rf_data;
        end
        if (fw_exe_i.valid && fw_exe_i.fwdable && fw_exe_i.addr == addr) begin
            return fw_exe_i.wdata;
        end
        if (fw_wb_i.valid && fw_wb_i.addr == addr) begin
            return fw_wb_i.wdata;
        end
        return rf_data;
    endfunction

    // alu result still being computed in exe
    function automatic logic exe_pending(input logic [`CORE_REG_ADDR_W-1:0] addr);
        return addr != '0 && fw_exe_i.valid && !fw_exe_i.fwdable && fw_exe_i.addr == addr;
    endfunction

    assign op1_o = fwd_value(ctrl_i.rs1, rs1_data_i);
    assign rs2_o = fwd_value(ctrl_i.rs2, rs2_data_i);
    assign op2_o = ctrl_i.op2_is_imm ? imm_i : rs2_o;

    assign hazard_o = (ctrl_i.use_rs1 && exe_pending(ctrl_i.rs1)) ||
                      (ctrl_i.use_rs2 && exe_pending(ctrl_i.rs2));

endmodule

// ==== verilog/execute_unit.sv ====
`timescale 1ns/1ps
`include "core_cfg.svh"

module execute_unit (
    input  core_pkg::ctrl_t       ctrl_i,
    input  logic [`CORE_XLEN-1:0] pc_i,
    input  logic [`CORE_XLEN-1:0] imm_i,
    input  logic [`CORE_XLEN-1:0] op1_i,
    input  logic [`CORE_XLEN-1:0] op2_i,
    input  logic [`CORE_XLEN-1:0] rs2_i,
    output logic [`CORE_XLEN-1:0] alu_out_o,
    output logic                  taken_o,
    output logic [`CORE_XLEN-1:0] target_o
);

    always_comb begin
        case (ctrl_i.alu_op)
            core_pkg::ALU_SUB: alu_out_o = op1_i - op2_i;
            core_pkg::ALU_IMM: alu_out_o = imm_i;
            default:           alu_out_o = op1_i + op2_i;
        endcase
    end

    // branch compare always against rs2, never the immediate
    always_comb begin
        case (ctrl_i.br_op)
            core_pkg::BR_BEQ: taken_o = (op1_i == rs2_i);
            core_pkg::BR_BNE: taken_o = (op1_i != rs2_i);
            core_pkg::BR_JAL: taken_o = 1'b1;
            default:          taken_o = 1'b0;
        endcase
    end

    // pc relative for both branches and jal
    assign target_o = pc_i + imm_i;

endmodule

// ==== verilog/core_top.sv ====
`timescale 1ns/1ps
`include "core_cfg.svh"

module core_top (
    input  logic                  clk,
    input  logic                  rst_i,
    input  core_pkg::fetch_resp_t iresp_i,
    output logic                  fetch_ready_o,
    output core_pkg::redirect_t   redirect_o,
    output core_pkg::retire_t     retire_o
);

    // id
    logic                   id_valid;
    core_pkg::stage_info_t  id_info;
    core_pkg::ctrl_t        id_ctrl;
    logic [`CORE_XLEN-1:0]  id_imm;

    // ds
    core_pkg::ds_payload_t  ds_d;
    core_pkg::ds_payload_t  ds_q;
    logic                   ds_valid;
    logic [`CORE_XLEN-1:0]  ds_rs1_data;
    logic [`CORE_XLEN-1:0]  ds_rs2_data;
    logic [`CORE_XLEN-1:0]  ds_op1;
    logic [`CORE_XLEN-1:0]  ds_op2;
    logic [`CORE_XLEN-1:0]  ds_rs2;
    logic                   ds_raw_hazard;

    // exe
    core_pkg::exe_payload_t exe_d;
    core_pkg::exe_payload_t exe_q;
    logic                   exe_valid;
    logic                   exe_is_new;
    logic                   exe_br_checked;
    logic [`CORE_XLEN-1:0]  exe_alu_out;
    logic                   exe_taken;
    logic [`CORE_XLEN-1:0]  exe_target;
    logic [`CORE_XLEN-1:0]  exe_next_pc;

    // wb
    core_pkg::wb_payload_t  wb_d;
    core_pkg::wb_payload_t  wb_q;
    logic                   wb_valid;

    core_pkg::fw_t          fw_exe;
    core_pkg::fw_t          fw_wb;

    logic exe_unchecked;
    logic branch_fail;
    logic exe_stall;
    logic ds_hazard;
    logic ds_stall;
    logic id_stall;
    logic id_flush;

    //////////////////////////////////////////////////
    // branch check, stall and flush
    //////////////////////////////////////////////////

    assign exe_next_pc   = exe_taken ? exe_target : exe_q.info.pc + `CORE_INST_BYTES;
    assign exe_unchecked = exe_valid && (exe_is_new || !exe_br_checked);

    // successor pc must match what exe computed
    assign branch_fail = exe_unchecked &&
                         (ds_valid ? (ds_q.info.pc != exe_next_pc) :
                          id_valid ? (id_info.pc != exe_next_pc) : 1'b0);

    // wait in exe until a successor shows up to check against
    assign exe_stall = (exe_unchecked && !ds_valid && !id_valid) || branch_fail;
    assign ds_hazard = ds_valid && ds_raw_hazard;
    assign ds_stall  = ds_hazard || (ds_valid && exe_stall);
    assign id_stall  = id_valid && ds_stall;
    assign id_flush  = branch_fail || redirect_o.valid;

    assign fetch_ready_o = !id_stall;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            redirect_o.valid <= 1'b0;
        end else begin
            redirect_o.valid <= branch_fail;
        end
        redirect_o.addr <= exe_next_pc;
    end

    // cleared by each accepted fetch, set once exe has redirected
    always_ff @(posedge clk) begin
        if (rst_i) begin
            exe_br_checked <= 1'b0;
        end else if (branch_fail) begin
            exe_br_checked <= 1'b1;
        end else if (!id_flush && !id_stall && iresp_i.valid) begin
            exe_br_checked <= 1'b0;
        end
    end

    //////////////////////////////////////////////////
    // id
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst_i || id_flush) begin
            id_valid <= 1'b0;
        end else if (!id_stall) begin
            id_valid <= iresp_i.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!id_stall) begin
            id_info.pc   <= iresp_i.pc;
            id_info.inst <= iresp_i.inst;
        end
    end

    inst_decode u_decode (
        .inst_i (id_info.inst),
        .ctrl_o (id_ctrl),
        .imm_o  (id_imm)
    );

    always_comb begin
        ds_d.info       = id_info;
        ds_d.ctrl       = id_ctrl;
        ds_d.imm        = id_imm;
        ds_d.fw.valid   = id_ctrl.rf_wen;
        ds_d.fw.fwdable = (id_ctrl.wb_sel == core_pkg::WB_PC);
        ds_d.fw.addr    = id_ctrl.rd;
        ds_d.fw.wdata   = id_info.pc + `CORE_INST_BYTES;
    end

    //////////////////////////////////////////////////
    // ds
    //////////////////////////////////////////////////

    stage_reg #(.payload_t(core_pkg::ds_payload_t)) u_ds_reg (
        .clk      (clk),
        .rst_i    (rst_i),
        .load_i   (id_valid && !ds_stall),
        .hold_i   (ds_stall),
        .flush_i  (branch_fail),
        .data_i   (ds_d),
        .valid_o  (ds_valid),
        .is_new_o (),
        .data_o   (ds_q)
    );

    // records only count while their stage holds a live instruction
    always_comb begin
        fw_exe       = exe_q.fw;
        fw_exe.valid = exe_valid && exe_q.fw.valid;
        fw_wb        = wb_q.fw;
        fw_wb.valid  = wb_valid && wb_q.fw.valid;
    end

    reg_file u_rf (
        .clk      (clk),
        .wen_i    (fw_wb.valid),
        .waddr_i  (fw_wb.addr),
        .wdata_i  (fw_wb.wdata),
        .raddr1_i (ds_q.ctrl.rs1),
        .raddr2_i (ds_q.ctrl.rs2),
        .rdata1_o (ds_rs1_data),
        .rdata2_o (ds_rs2_data)
    );

    operand_select u_opsel (
        .ctrl_i     (ds_q.ctrl),
        .imm_i      (ds_q.imm),
        .rs1_data_i (ds_rs1_data),
        .rs2_data_i (ds_rs2_data),
        .fw_exe_i   (fw_exe),
        .fw_wb_i    (fw_wb),
        .op1_o      (ds_op1),
        .op2_o      (ds_op2),
        .rs2_o      (ds_rs2),
        .hazard_o   (ds_raw_hazard)
    );

    always_comb begin
        exe_d.info = ds_q.info;
        exe_d.ctrl = ds_q.ctrl;
        exe_d.imm  = ds_q.imm;
        exe_d.op1  = ds_op1;
        exe_d.op2  = ds_op2;
        exe_d.rs2  = ds_rs2;
        exe_d.fw   = ds_q.fw;
    end

    //////////////////////////////////////////////////
    // exe
    //////////////////////////////////////////////////

    // hazard leaves a bubble behind
    stage_reg #(.payload_t(core_pkg::exe_payload_t)) u_exe_reg (
        .clk      (clk),
        .rst_i    (rst_i),
        .load_i   (ds_valid && !ds_hazard),
        .hold_i   (exe_stall),
        .flush_i  (1'b0),
        .data_i   (exe_d),
        .valid_o  (exe_valid),
        .is_new_o (exe_is_new),
        .data_o   (exe_q)
    );

    execute_unit u_exec (
        .ctrl_i    (exe_q.ctrl),
        .pc_i      (exe_q.info.pc),
        .imm_i     (exe_q.imm),
        .op1_i     (exe_q.op1),
        .op2_i     (exe_q.op2),
        .rs2_i     (exe_q.rs2),
        .alu_out_o (exe_alu_out),
        .taken_o   (exe_taken),
        .target_o  (exe_target)
    );

    always_comb begin
        wb_d.info       = exe_q.info;
        wb_d.fw         = exe_q.fw;
        wb_d.fw.fwdable = 1'b1;
        if (!exe_q.fw.fwdable) begin
            wb_d.fw.wdata = exe_alu_out;
        end
    end

    //////////////////////////////////////////////////
    // wb and retire
    //////////////////////////////////////////////////

    stage_reg #(.payload_t(core_pkg::wb_payload_t)) u_wb_reg (
        .clk      (clk),
        .rst_i    (rst_i),
        .load_i   (exe_valid && !exe_stall),
        .hold_i   (1'b0),
        .flush_i  (1'b0),
        .data_i   (wb_d),
        .valid_o  (wb_valid),
        .is_new_o (),
        .data_o   (wb_q)
    );

    always_ff @(posedge clk) begin
        if (rst_i) begin
            retire_o.valid <= 1'b0;
        end else begin
            retire_o.valid <= wb_valid;
        end
        retire_o.pc     <= wb_q.info.pc;
        retire_o.rf_wen <= wb_q.fw.valid;
        retire_o.rd     <= wb_q.fw.addr;
        retire_o.wdata  <= wb_q.fw.wdata;
    end

endmodule

// ==== testbench/core_props.sv ====
`timescale 1ns/1ps

module core_props (
    input logic                clk,
    input logic                rst_i,
    input core_pkg::redirect_t redirect_i,
    input core_pkg::retire_t   retire_i
);

    // redirect is a single-cycle pulse
    a_redirect_pulse: assert property (
        @(posedge clk) disable iff (rst_i)
        redirect_i.valid |=> !redirect_i.valid
    ) else $error("redirect valid high in two consecutive cycles");

    // quiet during reset and one cycle beyond
    a_quiet_in_reset: assert property (
        @(posedge clk)
        ($past(rst_i) || $past(rst_i, 2)) |-> (!retire_i.valid && !redirect_i.valid)
    ) else $error("retire or redirect valid during reset");

    a_no_x0_write: assert property (
        @(posedge clk) disable iff (rst_i)
        retire_i.valid |-> !(retire_i.rf_wen && retire_i.rd == '0)
    ) else $error("retire reports a register write to x0");

endmodule

// ==== testbench/core_tb.sv ====
`timescale 1ns/1ps
`include "core_cfg.svh"

module core_tb;

    localparam int          HALF_PERIOD   = 20;
    localparam int          MAX_ROWS      = 64;
    localparam int          ROW_WORDS     = 6;
    localparam int          RETIRE_BUDGET = 40;
    localparam int          SLACK_CYCLES  = 100;
    localparam logic [31:0] SEED          = 32'h26e9231c;
    localparam logic [31:0] NOP_INST      = 32'h0000_0013;

    logic                  clk;
    logic                  rst_i;
    core_pkg::fetch_resp_t iresp;
    logic                  fetch_ready;
    core_pkg::redirect_t   redirect;
    core_pkg::retire_t     retire;

    // raw rows of pc inst ret wen rd wdata
    logic [31:0]                 pat_mem   [0:MAX_ROWS*ROW_WORDS-1];
    logic [31:0]                 prog_pc   [0:MAX_ROWS-1];
    logic [31:0]                 prog_inst [0:MAX_ROWS-1];
    logic [31:0]                 exp_pc    [0:MAX_ROWS-1];
    logic                        exp_wen   [0:MAX_ROWS-1];
    logic [`CORE_REG_ADDR_W-1:0] exp_rd    [0:MAX_ROWS-1];
    logic [31:0]                 exp_wdata [0:MAX_ROWS-1];
    int                          n_prog  = 0;
    int                          n_exp   = 0;
    int                          exp_idx = 0;

    // fetch stream state
    logic [31:0] fetch_pc;
    logic        last_ready;
    int          gap;

    always #HALF_PERIOD clk = ~clk;

    core_top u_dut (
        .clk           (clk),
        .rst_i         (rst_i),
        .iresp_i       (iresp),
        .fetch_ready_o (fetch_ready),
        .redirect_o    (redirect),
        .retire_o      (retire)
    );

    bind core_top core_props u_props (
        .clk        (clk),
        .rst_i      (rst_i),
        .redirect_i (redirect_o),
        .retire_i   (retire_o)
    );

    task automatic load_patterns();
        int i;
        int row;
        int base;
        for (i = 0; i < MAX_ROWS * ROW_WORDS; i++) begin
            pat_mem[i] = '0;
        end
        $readmemh("testbench/core_patterns.txt", pat_mem);
        row = 0;
        // a zero pc ends the table
        while (row < MAX_ROWS && pat_mem[row*ROW_WORDS] != 32'h0) begin
            base              = row * ROW_WORDS;
            prog_pc[n_prog]   = pat_mem[base];
            prog_inst[n_prog] = pat_mem[base+1];
            n_prog++;
            if (pat_mem[base+2][0]) begin
                exp_pc[n_exp]    = pat_mem[base];
                exp_wen[n_exp]   = pat_mem[base+3][0];
                exp_rd[n_exp]    = pat_mem[base+4][`CORE_REG_ADDR_W-1:0];
                exp_wdata[n_exp] = pat_mem[base+5];
                n_exp++;
            end
            row++;
        end
        if (n_exp == 0) begin
            $display("Error: pattern file holds no expected retires");
            $display("TESTS FAILED");
            $fatal(1);
        end
    endtask

    function automatic logic [31:0] inst_at(input logic [31:0] pc);
        logic [31:0] word;
        int          i;
        word = NOP_INST;
        for (i = 0; i < n_prog; i++) begin
            if (prog_pc[i] == pc) begin
                word = prog_inst[i];
            end
        end
        return word;
    endfunction

    // one falling edge of the fetch stream
    task automatic fetch_step();
        logic                ready_now;
        core_pkg::redirect_t redirect_now;
        ready_now    = fetch_ready;
        redirect_now = redirect;
        if (iresp.valid && last_ready) begin
            fetch_pc    = fetch_pc + `CORE_INST_BYTES;
            gap         = int'($urandom % 3);
            iresp.valid = 1'b0;
        end
        if (redirect_now.valid) begin
            // drop what is queued, restart next cycle
            fetch_pc    = redirect_now.addr;
            iresp.valid = 1'b0;
        end else if (!iresp.valid) begin
            if (gap > 0) begin
                gap--;
            end else begin
                iresp.valid = 1'b1;
                iresp.pc    = fetch_pc;
                iresp.inst  = inst_at(fetch_pc);
            end
        end
        last_ready = ready_now;
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("Mismatch %s expected %h actual %h", name, expected, actual);
            $display("TESTS FAILED");
            $fatal(1);
        end
    endtask

    task automatic check_retire();
        string name;
        name = $sformatf("retire %0d pc %h", exp_idx, exp_pc[exp_idx]);
        check_value({name, " pc"}, exp_pc[exp_idx], retire.pc);
        check_value({name, " rf_wen"}, 32'(exp_wen[exp_idx]), 32'(retire.rf_wen));
        // rd and wdata mean nothing without a write
        if (exp_wen[exp_idx]) begin
            check_value({name, " rd"}, 32'(exp_rd[exp_idx]), 32'(retire.rd));
            check_value({name, " wdata"}, exp_wdata[exp_idx], retire.wdata);
        end
        exp_idx++;
    endtask

    ////////////////////////////////////////////////////
    // reset, fetch, checking and watchdog
    ////////////////////////////////////////////////////

    initial begin
        clk        = 1'b0;
        rst_i      = 1'b1;
        iresp      = '0;
        fetch_pc   = `CORE_RESET_PC;
        last_ready = 1'b0;
        gap        = 0;
        void'($urandom(SEED));
        load_patterns();
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_i = 1'b0;
        forever begin
            fetch_step();
            @(negedge clk);
        end
    end

    always @(negedge clk) begin
        if (retire.valid) begin
            check_retire();
            if (exp_idx == n_exp) begin
                $display("TESTS PASSED");
                $finish;
            end
        end
    end

    initial begin
        int limit;
        #1;
        limit = n_exp * RETIRE_BUDGET + SLACK_CYCLES;
        repeat (limit) @(posedge clk);
        $display("Error: retire output stalled after %0d of %0d instructions", exp_idx, n_exp);
        $display("TESTS FAILED");
        $fatal(1);
    end

endmodule

// ==== testbench/core_patterns.txt ====
// columns pc inst ret wen rd wdata
// ret is 0 for wrong-path words that must never retire
// straight-line and dependent alu code
1000 00500093 1 1 01 00000005
1004 12345137 1 1 02 12345000
1008 002081b3 1 1 03 12345005
100c 40118233 1 1 04 12345000
1010 00708013 1 0 00 00000000
// taken beq then not-taken bne
1014 00108663 1 0 00 00000000
1018 00100293 0 0 00 00000000
101c 00200293 0 0 00 00000000
1020 00109463 1 0 00 00000000
1024 01020313 1 1 06 12345010
1028 00431463 1 0 00 00000000
102c 06300393 0 0 00 00000000
// jal link used right away, then a jal that jumps
1030 0040046f 1 1 08 00001034
1034 00440493 1 1 09 00001038
1038 00948533 1 1 0a 00002070
103c 00c005ef 1 1 0b 00001040
1040 00100613 0 0 00 00000000
1044 00200613 0 0 00 00000000
1048 40a58633 1 1 0c ffffefd0

// ==== tb.f ====
+incdir+verilog
verilog/core_pkg.sv
verilog/stage_reg.sv
verilog/reg_file.sv
verilog/inst_decode.sv
verilog/operand_select.sv
verilog/execute_unit.sv
verilog/core_top.sv
testbench/core_props.sv
testbench/core_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       := core_tb
FILE_LIST := tb.f
VFLAGS    := --binary --timing --assert -j 0
OBJ_DIR   := obj_dir
LOG       := sim.log
PATTERNS  := testbench/core_patterns.txt
HEADERS   := verilog/core_cfg.svh

SIM_BIN := $(OBJ_DIR)/$(TOP)
SOURCES := $(filter-out +%,$(shell cat $(FILE_LIST))) $(HEADERS)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILE_LIST)
	$(VERILATOR) $(VFLAGS) -f $(FILE_LIST) --top-module $(TOP) --Mdir $(OBJ_DIR) -o $(TOP)

run: $(SIM_BIN) $(PATTERNS)
	./$(SIM_BIN) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "TESTS FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "TESTS PASSED" $(LOG) || { echo "simulation ended without a result"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
